// ==== logic/udp_rx_pkg.sv ====
// UDP receive offload package
// Stream and AXI write channel types, node identity and DMA buffer constants

package udp_rx_pkg;

    // Stream word geometry
    localparam int DATA_BYTES = 8;
    localparam int DATA_WIDTH = DATA_BYTES * 8;

    // Node identity
    localparam logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_00;
    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Protocol field values
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;

    // Words 0 to 4 carry header only, payload starts at byte 42
    localparam int HDR_BEATS = 5;
    localparam int PAYLOAD_SHIFT = 2;

    // Receive buffer
    localparam logic [31:0] DMA_BASE_ADDR = 32'h1000_0000;
    localparam int DMA_MAX_BYTES = 256;
    localparam int DMA_MAX_BEATS = DMA_MAX_BYTES / DATA_BYTES;

    // Input stream word, byte 0 of the wire in data[7:0]
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_BYTES-1:0] keep;
        logic last;
    } rx_beat_t;

    // Payload word realigned to lane 0
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic last;
    } payload_beat_t;

    typedef logic [15:0] payload_len_t;

    // AXI write address, size and burst type are fixed
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0] len;
    } axi_aw_t;

    // AXI write data
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_BYTES-1:0] strb;
        logic last;
    } axi_w_t;

    typedef logic [1:0] axi_resp_t;

endpackage

// ==== logic/udp_hdr_filter.sv ====
// Header filter for the receive path
// Checks Ethernet, IPv4 and UDP fields of each frame and forwards
// only the payload words of datagrams addressed to this node
`timescale 1ns/10ps

module udp_hdr_filter import udp_rx_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  rx_beat_t     rx,
    input  logic         rx_valid,
    output logic         rx_ready,
    output rx_beat_t     fwd,
    output logic         fwd_valid,
    input  logic         fwd_ready,
    output payload_len_t payload_len,
    output logic         len_valid,
    input  logic         len_ready
);

    typedef enum logic [1:0] {
        ST_HDR,
        ST_LEN,
        ST_PAYLOAD,
        ST_DROP
    } state_t;

    state_t state;
    logic [2:0] word_cnt;
    logic rx_fire;
    logic decide;

    // Checks collected from words 0 to 3
    logic mac_ok;
    logic type_ok;
    logic proto_ok;
    logic ip_hi_ok;

    // Fields taken straight from the current word
    logic [47:0] dst_mac;
    logic [15:0] ip_lo;
    logic [15:0] udp_len;
    logic accept;

    function automatic logic [7:0] lane_byte(input logic [DATA_WIDTH-1:0] d, input int idx);
        return d[8*idx +: 8];
    endfunction

    assign rx_fire = rx_valid && rx_ready;
    assign decide = word_cnt == 3'(HDR_BEATS - 1);

    assign dst_mac = {lane_byte(rx.data, 0), lane_byte(rx.data, 1), lane_byte(rx.data, 2),
                      lane_byte(rx.data, 3), lane_byte(rx.data, 4), lane_byte(rx.data, 5)};

    // Word 4 holds the low half of the destination IP and the UDP length
    assign ip_lo = {lane_byte(rx.data, 0), lane_byte(rx.data, 1)};
    assign udp_len = {lane_byte(rx.data, 6), lane_byte(rx.data, 7)};

    assign accept = mac_ok && type_ok && proto_ok && ip_hi_ok &&
                    (ip_lo == LOCAL_IP[15:0]) && (udp_len > 16'd8);

    // Payload words pass straight through, header and dropped words are sunk
    assign fwd = rx;

    always_comb begin
        rx_ready = 1'b1;
        fwd_valid = 1'b0;
        case (state)
            ST_LEN: begin
                rx_ready = 1'b0;
            end
            ST_PAYLOAD: begin
                rx_ready = fwd_ready;
                fwd_valid = rx_valid;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rx_fire && state == ST_HDR) begin
            case (word_cnt)
                3'd0: mac_ok <= (dst_mac == LOCAL_MAC) || (dst_mac == '1);
                // EtherType, then version and IHL in the same word
                3'd1: type_ok <= ({lane_byte(rx.data, 4), lane_byte(rx.data, 5)} ==
                                  ETHERTYPE_IPV4) && (lane_byte(rx.data, 6) == 8'h45);
                3'd2: proto_ok <= lane_byte(rx.data, 7) == IP_PROTO_UDP;
                3'd3: ip_hi_ok <= {lane_byte(rx.data, 6), lane_byte(rx.data, 7)} ==
                                  LOCAL_IP[31:16];
                default: begin
                end
            endcase
            if (decide) begin
                payload_len <= udp_len - 16'd8;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_HDR;
            word_cnt <= '0;
            len_valid <= 1'b0;
        end else begin
            case (state)
                ST_HDR: begin
                    if (rx_fire) begin
                        if (rx.last) begin
                            // Runt frame, resync on the next one
                            word_cnt <= '0;
                        end else if (decide) begin
                            word_cnt <= '0;
                            if (accept) begin
                                state <= ST_LEN;
                                len_valid <= 1'b1;
                            end else begin
                                state <= ST_DROP;
                            end
                        end else begin
                            word_cnt <= word_cnt + 3'd1;
                        end
                    end
                end
                ST_LEN: begin
                    if (len_ready) begin
                        len_valid <= 1'b0;
                        state <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD, ST_DROP: begin
                    if (rx_fire && rx.last) begin
                        state <= ST_HDR;
                    end
                end
                default: begin
                    state <= ST_HDR;
                end
            endcase
        end
    end

endmodule

// ==== logic/payload_realign.sv ====
// Payload realigner
// Shifts the payload down by two lanes so byte 42 of the frame lands in lane 0
`timescale 1ns/10ps

module payload_realign import udp_rx_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  rx_beat_t      fwd,
    input  logic          fwd_valid,
    output logic          fwd_ready,
    output payload_beat_t pay,
    output logic          pay_valid,
    input  logic          pay_ready
);

    // Upper lanes of the previous input word
    logic [DATA_WIDTH-8*PAYLOAD_SHIFT-1:0] hold_data;
    logic held;
    logic flush_pend;
    logic out_free;
    logic fwd_fire;

    assign out_free = !pay_valid || pay_ready;
    assign fwd_ready = out_free && !flush_pend;
    assign fwd_fire = fwd_valid && fwd_ready;

    always_ff @(posedge clk) begin
        if (fwd_fire) begin
            hold_data <= fwd.data[DATA_WIDTH-1:8*PAYLOAD_SHIFT];
            pay.data <= {fwd.data[8*PAYLOAD_SHIFT-1:0], hold_data};
            // Last here only if the final word adds no bytes past the shift
            pay.last <= fwd.last && !fwd.keep[PAYLOAD_SHIFT];
        end else if (flush_pend && out_free) begin
            pay.data <= {{(8*PAYLOAD_SHIFT){1'b0}}, hold_data};
            pay.last <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
            flush_pend <= 1'b0;
            pay_valid <= 1'b0;
        end else begin
            if (fwd_fire) begin
                // First word of a datagram only fills the holding register
                pay_valid <= held;
                held <= !fwd.last;
                flush_pend <= fwd.last && fwd.keep[PAYLOAD_SHIFT];
            end else if (flush_pend && out_free) begin
                pay_valid <= 1'b1;
                flush_pend <= 1'b0;
            end else if (pay_ready) begin
                pay_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/payload_dma_writer.sv ====
// Payload DMA writer
// Writes each datagram as one AXI4 INCR burst to the receive buffer
// and shows the low bits of the first payload byte on the LEDs
`timescale 1ns/10ps

module payload_dma_writer import udp_rx_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  payload_len_t  payload_len,
    input  logic          len_valid,
    output logic          len_ready,
    input  payload_beat_t pay,
    input  logic          pay_valid,
    output logic          pay_ready,
    output axi_aw_t       aw,
    output logic          aw_valid,
    input  logic          aw_ready,
    output axi_w_t        w,
    output logic          w_valid,
    input  logic          w_ready,
    input  axi_resp_t     b_resp,
    input  logic          b_valid,
    output logic          b_ready,
    output logic [1:0]    led
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_DRAIN,
        ST_RESP
    } state_t;

    state_t state;
    logic [8:0] burst_bytes;
    logic [8:0] burst_m1;
    logic [7:0] burst_len;
    logic [DATA_BYTES-1:0] last_strb;
    logic [7:0] beat_cnt;
    logic final_beat;
    logic w_fire;

    // Lanes written on the final word, all of them when the count is a whole word
    function automatic logic [DATA_BYTES-1:0] tail_strb(input logic [2:0] rem);
        logic [DATA_BYTES-1:0] strb;
        strb = '1;
        if (rem != 3'd0) begin
            strb = strb >> (DATA_BYTES - int'(rem));
        end
        return strb;
    endfunction

    // Cap at the buffer size
    assign burst_bytes = (payload_len > 16'(DMA_MAX_BYTES)) ? 9'(DMA_MAX_BYTES)
                                                             : payload_len[8:0];
    assign burst_m1 = burst_bytes - 9'd1;

    assign len_ready = state == ST_IDLE;

    assign aw.addr = DMA_BASE_ADDR;
    assign aw.len = burst_len;
    assign aw_valid = state == ST_ADDR;

    assign final_beat = beat_cnt == burst_len;
    assign w.data = pay.data;
    assign w.strb = final_beat ? last_strb : '1;
    assign w.last = final_beat;
    assign w_valid = (state == ST_DATA) && pay_valid;
    assign w_fire = w_valid && w_ready;

    // Words past the cap are sunk in the drain state
    assign pay_ready = ((state == ST_DATA) && w_ready) || (state == ST_DRAIN);

    // Any response code ends the burst
    assign b_ready = state == ST_RESP;

    always_ff @(posedge clk) begin
        if (len_valid && len_ready) begin
            burst_len <= 8'(burst_m1 >> $clog2(DATA_BYTES));
            last_strb <= tail_strb(burst_bytes[2:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            beat_cnt <= '0;
            led <= 2'b00;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (len_valid) begin
                        beat_cnt <= '0;
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (aw_ready) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        if (beat_cnt == 8'd0) begin
                            led <= pay.data[1:0];
                        end
                        if (final_beat) begin
                            state <= pay.last ? ST_RESP : ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (pay_valid && pay.last) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (b_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/udp_rx_core.sv ====
// UDP receive offload core
// Header filter, payload realigner and AXI4 DMA writer in a chain
`timescale 1ns/10ps

module udp_rx_core import udp_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  rx_beat_t   rx,
    input  logic       rx_valid,
    output logic       rx_ready,
    output axi_aw_t    aw,
    output logic       aw_valid,
    input  logic       aw_ready,
    output axi_w_t     w,
    output logic       w_valid,
    input  logic       w_ready,
    input  axi_resp_t  b_resp,
    input  logic       b_valid,
    output logic       b_ready,
    output logic [1:0] led
);

    // Filter to realigner
    rx_beat_t fwd;
    logic fwd_valid;
    logic fwd_ready;

    // Filter to writer
    payload_len_t payload_len;
    logic len_valid;
    logic len_ready;

    // Realigner to writer
    payload_beat_t pay;
    logic pay_valid;
    logic pay_ready;

    udp_hdr_filter udp_hdr_filter_i (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .fwd         (fwd),
        .fwd_valid   (fwd_valid),
        .fwd_ready   (fwd_ready),
        .payload_len (payload_len),
        .len_valid   (len_valid),
        .len_ready   (len_ready)
    );

    payload_realign payload_realign_i (
        .clk       (clk),
        .rst       (rst),
        .fwd       (fwd),
        .fwd_valid (fwd_valid),
        .fwd_ready (fwd_ready),
        .pay       (pay),
        .pay_valid (pay_valid),
        .pay_ready (pay_ready)
    );

    payload_dma_writer payload_dma_writer_i (
        .clk         (clk),
        .rst         (rst),
        .payload_len (payload_len),
        .len_valid   (len_valid),
        .len_ready   (len_ready),
        .pay         (pay),
        .pay_valid   (pay_valid),
        .pay_ready   (pay_ready),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b_resp      (b_resp),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .led         (led)
    );

endmodule

// ==== verif/udp_rx_chk.sv ====
// AXI write channel checks for the UDP receive core
// Reset state, stable payloads under back-pressure, burst limits and AW before W
`timescale 1ns/10ps

module udp_rx_chk import udp_rx_pkg::*; (
    input logic    clk,
    input logic    rst,
    input axi_aw_t aw,
    input logic    aw_valid,
    input logic    aw_ready,
    input axi_w_t  w,
    input logic    w_valid,
    input logic    w_ready
);

    // Open from the AW handshake until the last W word
    logic aw_open;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_open <= 1'b0;
        end else if (aw_valid && aw_ready) begin
            aw_open <= 1'b1;
        end else if (w_valid && w_ready && w.last) begin
            aw_open <= 1'b0;
        end
    end

    idle_after_reset: assert property (@(posedge clk) rst |=> !aw_valid && !w_valid)
        else $error("AW or W valid in the cycle after reset");

    aw_stable: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW dropped or changed while stalled");

    w_stable: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("W dropped or changed while stalled");

    aw_len_cap: assert property (@(posedge clk) disable iff (rst)
        aw_valid |-> aw.len <= 8'(DMA_MAX_BEATS - 1))
        else $error("AW burst length above the buffer cap");

    w_after_aw: assert property (@(posedge clk) disable iff (rst) w_valid |-> aw_open)
        else $error("W valid before the burst address was accepted");

endmodule

// ==== verif/udp_rx_tb.sv ====
// Testbench for the UDP receive offload core
// Sends directed Ethernet frames and checks the AXI bursts written to memory
`timescale 1ns/10ps

module udp_rx_tb import udp_rx_pkg::*; ();

    typedef logic [7:0] byte_q_t[$];
    typedef rx_beat_t beat_q_t[$];

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int HDR_BYTES = 42;
    // Payload sizes in test order and the base of the watchdog budget
    localparam int PL_SIZES [11] = '{5, 100, 20, 20, 20, 20, 30, 300, 12, 64, 90};

    logic clk = 1'b0;
    logic rst;
    rx_beat_t rx;
    logic rx_valid;
    logic rx_ready;
    axi_aw_t aw;
    logic aw_valid;
    logic aw_ready;
    axi_w_t w;
    logic w_valid;
    logic w_ready;
    axi_resp_t b_resp;
    logic b_valid;
    logic b_ready;
    logic [1:0] led;

    // Memory side bookkeeping
    axi_aw_t aw_got[$];
    axi_w_t w_got[$];
    int bursts_done = 0;
    int bursts_exp = 0;
    bit b_pend = 1'b0;
    bit stall_on = 1'b0;
    logic [31:0] lcg_main = 32'd40;
    logic [31:0] lcg_resp = 32'd40;

    // LED value of the last accepted datagram
    logic [1:0] led_exp = 2'b00;

    udp_rx_core udp_rx_core_i (.*);

    bind udp_rx_core udp_rx_chk udp_rx_chk_i (
        .clk(clk), .rst(rst), .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready));

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [7:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state[30:23];
    endfunction

    function automatic void make_payload(input int n, output byte_q_t pl);
        pl = {};
        repeat (n) pl.push_back(lcg_next(lcg_main));
    endfunction

    // Ethernet, IPv4 and UDP headers followed by the payload in 8-byte words
    function automatic void build_frame(input logic [47:0] mac, input logic [31:0] ip,
                                        input logic [7:0] proto, input byte_q_t pl,
                                        output beat_q_t beats);
        logic [8*HDR_BYTES-1:0] hdr;
        logic [15:0] udp_len;
        byte_q_t b;
        rx_beat_t bt;
        udp_len = 16'(pl.size() + 8);
        hdr = {mac, 48'h02_00_00_00_00_01, ETHERTYPE_IPV4, 8'h45, 8'h00, udp_len + 16'd20,
               32'h0, 8'd64, proto, 16'h0, 32'hc0a8_0101, ip, 16'd1234, 16'd5678,
               udp_len, 16'h0};
        b = {};
        for (int i = 0; i < HDR_BYTES; i++) begin
            b.push_back(hdr[8*(HDR_BYTES-1-i) +: 8]);
        end
        foreach (pl[i]) b.push_back(pl[i]);
        beats = {};
        for (int i = 0; i < b.size(); i += DATA_BYTES) begin
            bt = '0;
            for (int j = 0; j < DATA_BYTES && i + j < b.size(); j++) begin
                bt.data[8*j +: 8] = b[i+j];
                bt.keep[j] = 1'b1;
            end
            bt.last = i + DATA_BYTES >= b.size();
            beats.push_back(bt);
        end
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_aw(input string name, input axi_aw_t exp, input axi_aw_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: AW expected addr %h len %0d, actual addr %h len %0d",
                                name, exp.addr, exp.len, act.addr, act.len));
        end
    endtask

    task automatic compare_w(input string name, input axi_w_t exp, input axi_w_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: W expected %h/%h/%b, actual %h/%h/%b", name,
                                exp.data, exp.strb, exp.last, act.data, act.strb, act.last));
        end
    endtask

    task automatic compare_led(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: LED expected %b, actual %b", name, exp, act));
        end
    endtask

    // Starts and returns on a falling edge
    task automatic send_frame(input beat_q_t beats, input bit gaps);
        foreach (beats[i]) begin
            while (gaps && lcg_next(lcg_main) < 8'd80) begin
                rx_valid = 1'b0;
                @(negedge clk);
            end
            rx = beats[i];
            rx_valid = 1'b1;
            #10;
            while (!rx_ready) begin
                @(negedge clk);
                #10;
            end
            @(negedge clk);
        end
        rx_valid = 1'b0;
    endtask

    task automatic wait_bursts();
        while (bursts_done != bursts_exp) @(negedge clk);
    endtask

    // Expected burst from the cap, whole words and tail strobes
    task automatic check_burst(input string name, input byte_q_t pl);
        int n;
        int nbytes;
        int nwords;
        int idx;
        axi_aw_t exp_aw;
        axi_w_t exp_w;
        n = pl.size();
        nbytes = (n > DMA_MAX_BYTES) ? DMA_MAX_BYTES : n;
        nwords = (nbytes + DATA_BYTES - 1) / DATA_BYTES;
        if (aw_got.size() == 0 || w_got.size() < nwords) begin
            abort_run($sformatf("Test %s: the burst address or data words never came", name));
        end
        exp_aw.addr = DMA_BASE_ADDR;
        exp_aw.len = 8'(nwords - 1);
        compare_aw(name, exp_aw, aw_got.pop_front());
        for (int k = 0; k < nwords; k++) begin
            exp_w = '0;
            for (int j = 0; j < DATA_BYTES; j++) begin
                idx = DATA_BYTES * k + j;
                if (idx < n) begin
                    exp_w.data[8*j +: 8] = pl[idx];
                end
                exp_w.strb[j] = idx < nbytes;
            end
            exp_w.last = k == nwords - 1;
            compare_w(name, exp_w, w_got.pop_front());
        end
    endtask

    task automatic run_good(input string name, input logic [47:0] mac, input int n);
        byte_q_t pl;
        beat_q_t beats;
        make_payload(n, pl);
        build_frame(mac, LOCAL_IP, IP_PROTO_UDP, pl, beats);
        send_frame(beats, 1'b0);
        bursts_exp++;
        wait_bursts();
        check_burst(name, pl);
        led_exp = pl[0][1:0];
        compare_led(name, led_exp, led);
    endtask

    task automatic send_reject(input string name, input logic [47:0] mac,
                               input logic [31:0] ip, input logic [7:0] proto, input int n);
        byte_q_t pl;
        beat_q_t beats;
        make_payload(n, pl);
        build_frame(mac, ip, proto, pl, beats);
        send_frame(beats, 1'b0);
        // Room for a wrongly accepted frame to reach memory
        repeat (20) @(negedge clk);
        if (bursts_done != bursts_exp || aw_got.size() != 0) begin
            abort_run($sformatf("Test %s: a rejected frame was written to memory", name));
        end
        compare_led(name, led_exp, led);
    endtask

    task automatic test_short();
        run_good("short", LOCAL_MAC, PL_SIZES[0]);
    endtask

    task automatic test_multi_word();
        run_good("multi_word", LOCAL_MAC, PL_SIZES[1]);
    endtask

    task automatic test_reject();
        run_good("broadcast", '1, PL_SIZES[2]);
        send_reject("wrong_mac", 48'h02_00_00_00_00_07, LOCAL_IP, IP_PROTO_UDP, PL_SIZES[3]);
        send_reject("wrong_ip", LOCAL_MAC, LOCAL_IP ^ 32'h1, IP_PROTO_UDP, PL_SIZES[4]);
        send_reject("tcp", LOCAL_MAC, LOCAL_IP, 8'd6, PL_SIZES[5]);
        run_good("after_reject", LOCAL_MAC, PL_SIZES[6]);
    endtask

    task automatic test_oversize();
        run_good("oversize", LOCAL_MAC, PL_SIZES[7]);
        run_good("after_oversize", LOCAL_MAC, PL_SIZES[8]);
    endtask

    task automatic test_backpressure();
        byte_q_t pl_a;
        byte_q_t pl_b;
        beat_q_t beats_a;
        beat_q_t beats_b;
        make_payload(PL_SIZES[9], pl_a);
        make_payload(PL_SIZES[10], pl_b);
        build_frame(LOCAL_MAC, LOCAL_IP, IP_PROTO_UDP, pl_a, beats_a);
        build_frame(LOCAL_MAC, LOCAL_IP, IP_PROTO_UDP, pl_b, beats_b);
        stall_on = 1'b1;
        send_frame(beats_a, 1'b1);
        send_frame(beats_b, 1'b1);
        bursts_exp += 2;
        wait_bursts();
        stall_on = 1'b0;
        check_burst("backpressure_a", pl_a);
        check_burst("backpressure_b", pl_b);
        led_exp = pl_b[0][1:0];
        compare_led("backpressure_b", led_exp, led);
    endtask

    // Memory responder that always answers OKAY
    initial begin
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        b_resp = 2'b00;
        forever begin
            @(negedge clk);
            aw_ready = !stall_on || lcg_next(lcg_resp) > 8'd90;
            w_ready = !stall_on || lcg_next(lcg_resp) > 8'd90;
            b_valid = b_pend;
            #10;
            if (aw_valid && aw_ready) begin
                aw_got.push_back(aw);
            end
            if (w_valid && w_ready) begin
                w_got.push_back(w);
                b_pend = b_pend || w.last;
            end
            if (b_valid && b_ready) begin
                b_pend = 1'b0;
                bursts_done++;
            end
        end
    end

    // Budget of a few cycles per frame word plus room for the reject waits
    initial begin
        int words;
        words = 0;
        foreach (PL_SIZES[i]) words += (HDR_BYTES + PL_SIZES[i] + DATA_BYTES - 1) / DATA_BYTES;
        #(CLK_PERIOD * (RESET_CYCLES + 4 * words + 300));
        abort_run("Watchdog timeout, the DUT stopped finishing datagrams");
    end

    initial begin
        rst = 1'b1;
        rx = '0;
        rx_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        test_short();
        test_multi_word();
        test_reject();
        test_oversize();
        test_backpressure();
        if (aw_got.size() != 0 || w_got.size() != 0 || bursts_done != bursts_exp) begin
            abort_run("Extra AXI writes were left over at the end of the run");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
logic/udp_rx_pkg.sv
logic/udp_hdr_filter.sv
logic/payload_realign.sv
logic/payload_dma_writer.sv
logic/udp_rx_core.sv
verif/udp_rx_chk.sv
verif/udp_rx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UDP receive testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module udp_rx_tb -o udp_rx_sim &&
./obj_dir/udp_rx_sim || exit 1
